/* hdl/soc_pkg.sv */
package soc_pkg;

    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;
    typedef logic [31:0] ram_word_t;
    typedef logic [9:0]  ram_index_t;   // word index into the 4 KiB RAM
    typedef logic [2:0]  plic_prio_t;
    typedef logic [31:0] plic_mask_t;   // one bit per interrupt source

    // plic register selector
    // sel[3] low means priority, sel[2:0] is the source id
    // sel[3:2] is PSEL_ENABLE or PSEL_THRESH otherwise, sel[0] is the context
    typedef logic [3:0]  preg_sel_t;

    typedef enum logic [2:0] {
        ls_b  = 3'd0,
        ls_h  = 3'd1,
        ls_w  = 3'd2,
        ls_d  = 3'd3,
        ls_bu = 3'd4,
        ls_hu = 3'd5,
        ls_wu = 3'd6
    } ls_type_e;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_beat2,   // upper word of a double
        st_done
    } fabric_state_e;

    localparam bus_addr_t RAM_BASE       = 64'h0000_0000_8000_0000;
    localparam int        RAM_WORDS      = 1024;
    localparam bus_addr_t RAM_BYTES      = 64'(RAM_WORDS * 4);

    localparam bus_addr_t MTIME_ADDR     = 64'h0000_0000_0200_BFF8;
    localparam bus_addr_t MTIMECMP_ADDR  = 64'h0000_0000_0200_4000;
    localparam bus_data_t MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    localparam bus_addr_t PLIC_BASE         = 64'h0000_0000_0C00_0000;
    localparam int        PLIC_SOURCES      = 6;
    localparam bus_addr_t PLIC_PENDING      = PLIC_BASE + 64'h1000;
    localparam bus_addr_t PLIC_ENABLE       = PLIC_BASE + 64'h2000;
    localparam bus_addr_t CTX_ENABLE_STRIDE = 64'h80;
    localparam bus_addr_t PLIC_THRESHOLD    = PLIC_BASE + 64'h20_0000;
    localparam bus_addr_t PLIC_CLAIM        = PLIC_BASE + 64'h20_0004;
    localparam bus_addr_t CTX_STRIDE        = 64'h1000;
    localparam int        UART_IRQ_ID       = 1;

    localparam logic [1:0] PSEL_ENABLE = 2'b10;
    localparam logic [1:0] PSEL_THRESH = 2'b11;

endpackage

/* hdl/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_addr_t   bus_address,
    input  ls_type_e    bus_ls_type,
    input  bus_data_t   bus_write_data,
    input  logic        bus_read_enable,
    input  logic        bus_write_enable,
    output bus_data_t   bus_read_data,
    output logic        bus_read_done,
    output logic        bus_write_done,
    output ram_index_t  ram_index,
    output logic [1:0]  ram_offset,
    output ls_type_e    ram_type,
    output logic        ram_we,
    output ram_word_t   ram_wdata,
    output logic        ram_beat,
    input  bus_data_t   ram_rdata,
    output logic        preg_we,
    output preg_sel_t   preg_sel,
    output plic_mask_t  preg_wdata,
    input  plic_mask_t  preg_rdata,
    output logic        claim_strobe,
    output logic        claim_ctx,
    input  plic_mask_t  claim_id,
    input  plic_mask_t  pending,
    output logic        cmp_we,
    output bus_data_t   cmp_wdata,
    input  bus_data_t   mtime,
    input  bus_data_t   mtimecmp
);

    fabric_state_e state;
    logic hit_ram, hit_mtime, hit_cmp, hit_prio, hit_pend, hit_en, hit_thr, hit_claim;
    logic hit_ctx1;
    logic wr_req, accept, dbl, step2, finish;
    logic write_q;
    logic tgt_ram_q, tgt_mtime_q, tgt_cmp_q, tgt_preg_q, tgt_pend_q, tgt_claim_q;
    preg_sel_t sel_next;
    bus_data_t reg_rdata;
    bus_data_t rd_q;

    // decode of the held address
    assign hit_ram   = bus_address >= RAM_BASE && bus_address < RAM_BASE + RAM_BYTES;
    assign hit_mtime = bus_address == MTIME_ADDR;
    assign hit_cmp   = bus_address == MTIMECMP_ADDR;
    assign hit_prio  = bus_address >= PLIC_BASE &&
                       bus_address < PLIC_BASE + bus_addr_t'(4 * PLIC_SOURCES);
    assign hit_pend  = bus_address == PLIC_PENDING;
    assign hit_en    = bus_address == PLIC_ENABLE ||
                       bus_address == PLIC_ENABLE + CTX_ENABLE_STRIDE;
    assign hit_thr   = bus_address == PLIC_THRESHOLD ||
                       bus_address == PLIC_THRESHOLD + CTX_STRIDE;
    assign hit_claim = bus_address == PLIC_CLAIM ||
                       bus_address == PLIC_CLAIM + CTX_STRIDE;
    assign hit_ctx1  = bus_address == PLIC_ENABLE + CTX_ENABLE_STRIDE ||
                       bus_address == PLIC_THRESHOLD + CTX_STRIDE ||
                       bus_address == PLIC_CLAIM + CTX_STRIDE;

    always_comb begin
        if (hit_en) begin
            sel_next = {PSEL_ENABLE, 1'b0, hit_ctx1};
        end else if (hit_thr) begin
            sel_next = {PSEL_THRESH, 1'b0, hit_ctx1};
        end else begin
            sel_next = {1'b0, bus_address[4:2]};   // priority id
        end
    end

    assign wr_req = bus_write_enable && !bus_read_enable;  // read wins a double strobe
    assign accept = (state == st_idle || state == st_done) &&
                    (bus_read_enable || bus_write_enable);
    assign dbl    = tgt_ram_q && ram_type == ls_d;
    assign step2  = state == st_access && dbl;
    assign finish = (state == st_access && !dbl) || state == st_beat2;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_idle;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            write_q        <= 1'b0;
            ram_we         <= 1'b0;
            preg_we        <= 1'b0;
            claim_strobe   <= 1'b0;
            cmp_we         <= 1'b0;
            tgt_ram_q      <= 1'b0;
            tgt_mtime_q    <= 1'b0;
            tgt_cmp_q      <= 1'b0;
            tgt_preg_q     <= 1'b0;
            tgt_pend_q     <= 1'b0;
            tgt_claim_q    <= 1'b0;
        end else begin
            ram_we       <= 1'b0;    // all strobes last one cycle
            preg_we      <= 1'b0;
            claim_strobe <= 1'b0;
            cmp_we       <= 1'b0;
            if (accept) begin
                bus_read_done  <= wr_req;
                bus_write_done <= !wr_req;
                write_q        <= wr_req;
                tgt_ram_q      <= hit_ram;
                tgt_mtime_q    <= hit_mtime;
                tgt_cmp_q      <= hit_cmp;
                tgt_preg_q     <= hit_prio || hit_en || hit_thr;
                tgt_pend_q     <= hit_pend;
                tgt_claim_q    <= hit_claim;
                ram_we         <= wr_req && hit_ram;
                preg_we        <= wr_req && (hit_prio || hit_en || hit_thr);
                cmp_we         <= wr_req && hit_cmp;
                claim_strobe   <= !wr_req && hit_claim;  // reading the claim clears pending
                state          <= st_access;
            end else if (step2) begin
                ram_we <= write_q;
                state  <= st_beat2;
            end else if (finish) begin
                bus_read_done  <= 1'b1;
                bus_write_done <= 1'b1;
                state          <= st_done;
            end
        end
    end

    always_comb begin
        if (tgt_mtime_q) begin
            reg_rdata = mtime;
        end else if (tgt_cmp_q) begin
            reg_rdata = mtimecmp;
        end else if (tgt_preg_q) begin
            reg_rdata = {32'b0, preg_rdata};
        end else if (tgt_pend_q) begin
            reg_rdata = {32'b0, pending};
        end else if (tgt_claim_q) begin
            reg_rdata = {32'b0, claim_id};
        end else begin
            reg_rdata = '0;    // unmapped
        end
    end

    // request payload
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            ram_index  <= bus_address[11:2];
            ram_offset <= bus_address[1:0];
            ram_type   <= bus_ls_type;
            ram_wdata  <= bus_write_data[31:0];
            ram_beat   <= 1'b0;
            preg_sel   <= sel_next;
            preg_wdata <= bus_write_data[31:0];
            cmp_wdata  <= bus_write_data;
            claim_ctx  <= hit_ctx1;
        end
        if (step2) begin
            ram_index <= ram_index + 1'b1;    // next word, upper half
            ram_wdata <= bus_write_data[63:32];
            ram_beat  <= 1'b1;
        end
        if (finish) begin
            rd_q <= reg_rdata;
        end
    end

    // ram data comes straight from its output register
    assign bus_read_data = (state == st_done) ? (tgt_ram_q ? ram_rdata : rd_q) : '0;

endmodule

/* hdl/local_ram.sv */
`timescale 1ns/1ps

module local_ram import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  ram_index_t index,
    input  logic [1:0] offset,
    input  ls_type_e   ls_type,
    input  logic       we,
    input  ram_word_t  wdata,
    input  logic       beat,
    output bus_data_t  rdata
);

    ram_word_t  mem [0:RAM_WORDS-1];
    ram_word_t  lo_q;
    ram_word_t  hi_q;
    ram_word_t  lane_data;
    ram_word_t  shifted;
    logic [3:0] lane_en;

    // byte lanes, little endian
    always_comb begin
        case (ls_type)
            ls_b: begin
                lane_en   = 4'b0001 << offset;
                lane_data = {4{wdata[7:0]}};
            end
            ls_h: begin
                lane_en   = offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wdata[15:0]}};
            end
            default: begin          // sw and both sd beats
                lane_en   = 4'b1111;
                lane_data = wdata;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we && lane_en[lane]) begin
                mem[index][8*lane +: 8] <= lane_data[8*lane +: 8];
            end
        end
        if (beat) begin
            hi_q <= mem[index];
        end else begin
            lo_q <= mem[index];    // kept while the second beat runs
        end
    end

    assign shifted = lo_q >> {offset, 3'b000};

    always_comb begin
        case (ls_type)
            ls_b:    rdata = {{56{shifted[7]}}, shifted[7:0]};
            ls_bu:   rdata = {56'b0, shifted[7:0]};
            ls_h:    rdata = {{48{shifted[15]}}, shifted[15:0]};
            ls_hu:   rdata = {48'b0, shifted[15:0]};
            ls_w:    rdata = {{32{shifted[31]}}, shifted};
            ls_wu:   rdata = {32'b0, shifted};
            default: rdata = {hi_q, lo_q};   // ld
        endcase
    end

endmodule

/* hdl/plic_regs.sv */
`timescale 1ns/1ps

module plic_regs import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       we,
    input  preg_sel_t  sel,
    input  plic_mask_t wdata,
    output plic_mask_t rdata,
    output plic_mask_t enable0,
    output plic_mask_t enable1
);

    plic_prio_t prio [0:PLIC_SOURCES-1];
    plic_mask_t enable [0:1];
    plic_prio_t threshold [0:1];    // stored only, the claim ignores it

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < PLIC_SOURCES; i++) begin
                prio[i] <= '0;
            end
            enable[0]    <= '0;
            enable[1]    <= '0;
            threshold[0] <= '0;
            threshold[1] <= '0;
        end else if (we) begin
            case (sel[3:2])
                PSEL_ENABLE: enable[sel[0]] <= wdata;
                PSEL_THRESH: threshold[sel[0]] <= wdata[2:0];
                default: begin
                    if (sel[2:0] < PLIC_SOURCES) begin
                        prio[sel[2:0]] <= wdata[2:0];
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (sel[3:2])
            PSEL_ENABLE: rdata = enable[sel[0]];
            PSEL_THRESH: rdata = plic_mask_t'(threshold[sel[0]]);
            default: begin
                if (sel[2:0] < PLIC_SOURCES) begin
                    rdata = plic_mask_t'(prio[sel[2:0]]);
                end else begin
                    rdata = '0;
                end
            end
        endcase
    end

    assign enable0 = enable[0];  // machine context
    assign enable1 = enable[1];  // supervisor context

endmodule

/* hdl/plic_gateway.sv */
`timescale 1ns/1ps

module plic_gateway import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ext_irq,
    input  plic_mask_t enable0,
    input  plic_mask_t enable1,
    input  logic       claim_strobe,
    input  logic       claim_ctx,
    output plic_mask_t claim_id,
    output plic_mask_t pending,
    output logic       meip,
    output logic       seip
);

    logic       irq_s;     // synchroniser stage
    logic       irq_d;
    plic_mask_t claim0;
    plic_mask_t claim1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_s   <= 1'b0;
            irq_d   <= 1'b0;
            pending <= '0;
        end else begin
            irq_s <= ext_irq;
            irq_d <= irq_s;
            if (claim_strobe && claim_id != '0) begin
                pending[claim_id[4:0]] <= 1'b0;
            end
            if (irq_s && !irq_d) begin
                pending[UART_IRQ_ID] <= 1'b1;  // a new edge wins over a claim
            end
        end
    end

    // only one source, so no priority compare
    assign claim0 = (pending[UART_IRQ_ID] && enable0[UART_IRQ_ID]) ?
                    plic_mask_t'(UART_IRQ_ID) : '0;
    assign claim1 = (pending[UART_IRQ_ID] && enable1[UART_IRQ_ID]) ?
                    plic_mask_t'(UART_IRQ_ID) : '0;

    assign claim_id = claim_ctx ? claim1 : claim0;
    assign meip     = claim0 != '0;
    assign seip     = claim1 != '0;

endmodule

/* hdl/machine_timer.sv */
`timescale 1ns/1ps

module machine_timer import soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      cmp_we,
    input  bus_data_t cmp_wdata,
    output bus_data_t mtime,
    output bus_data_t mtimecmp,
    output logic      mtip
);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= MTIMECMP_RESET;
        end else begin
            mtime <= mtime + 1'b1;   // one tick per clock
            if (cmp_we) begin
                mtimecmp <= cmp_wdata;
            end
        end
    end

    // unsigned compare
    assign mtip = mtime >= mtimecmp;

endmodule

/* hdl/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top import soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  bus_addr_t bus_address,
    input  ls_type_e  bus_ls_type,
    input  bus_data_t bus_write_data,
    input  logic      bus_read_enable,
    input  logic      bus_write_enable,
    output bus_data_t bus_read_data,
    output logic      bus_read_done,
    output logic      bus_write_done,
    input  logic      ext_irq,
    output logic      meip,
    output logic      seip,
    output logic      mtip
);

    ram_index_t ram_index;
    logic [1:0] ram_offset;
    ls_type_e   ram_type;
    logic       ram_we;
    ram_word_t  ram_wdata;
    logic       ram_beat;
    bus_data_t  ram_rdata;
    logic       preg_we;
    preg_sel_t  preg_sel;
    plic_mask_t preg_wdata;
    plic_mask_t preg_rdata;
    plic_mask_t enable0;
    plic_mask_t enable1;
    logic       claim_strobe;
    logic       claim_ctx;
    plic_mask_t claim_id;
    plic_mask_t pending;
    logic       cmp_we;
    bus_data_t  cmp_wdata;
    bus_data_t  mtime;
    bus_data_t  mtimecmp;

    bus_fabric i_fabric (
        .CLOCK_50, .KEY0,
        .bus_address, .bus_ls_type, .bus_write_data,
        .bus_read_enable, .bus_write_enable,
        .bus_read_data, .bus_read_done, .bus_write_done,
        .ram_index, .ram_offset, .ram_type, .ram_we, .ram_wdata, .ram_beat, .ram_rdata,
        .preg_we, .preg_sel, .preg_wdata, .preg_rdata,
        .claim_strobe, .claim_ctx, .claim_id, .pending,
        .cmp_we, .cmp_wdata, .mtime, .mtimecmp
    );

    local_ram i_ram (
        .CLOCK_50,
        .index   (ram_index),
        .offset  (ram_offset),
        .ls_type (ram_type),
        .we      (ram_we),
        .wdata   (ram_wdata),
        .beat    (ram_beat),
        .rdata   (ram_rdata)
    );

    plic_regs i_plic_regs (
        .CLOCK_50, .KEY0,
        .we    (preg_we),
        .sel   (preg_sel),
        .wdata (preg_wdata),
        .rdata (preg_rdata),
        .enable0, .enable1
    );

    plic_gateway i_plic_gateway (
        .CLOCK_50, .KEY0,
        .ext_irq, .enable0, .enable1,
        .claim_strobe, .claim_ctx, .claim_id, .pending,
        .meip, .seip
    );

    machine_timer i_timer (
        .CLOCK_50, .KEY0,
        .cmp_we, .cmp_wdata, .mtime, .mtimecmp, .mtip
    );

endmodule

/* sim/tb_bus_tasks.svh */
// test bookkeeping
int    test_count  = 0;
int    check_count = 0;
int    fail_count  = 0;
int    test_checks_at_start;
int    test_fails_at_start;
string test_name;

localparam int DONE_LIMIT = 50;   // cycles, far above the slowest access

task automatic start_test(input string name);
    test_name            = name;
    test_checks_at_start = check_count;
    test_fails_at_start  = fail_count;
endtask

task automatic finish_test();
    int fails;
    fails = fail_count - test_fails_at_start;
    test_count++;
    if (fails == 0) begin
        $display("test %-16s ok, %0d checks", test_name, check_count - test_checks_at_start);
    end else begin
        $display("test %-16s failed %0d of %0d checks", test_name, fails,
                 check_count - test_checks_at_start);
    end
endtask

// values are compared by the assertion in the testbench top
task automatic check(input string name, input bus_data_t got, input bus_data_t exp);
    @(negedge CLOCK_50);
    chk_name  = name;
    chk_got   = got;
    chk_exp   = exp;
    chk_valid = 1'b1;
    check_count++;
    @(negedge CLOCK_50);
    chk_valid = 1'b0;
endtask

task automatic wait_done(input bus_addr_t addr);
    int cycles;
    cycles = 0;
    while (!(bus_read_done && bus_write_done)) begin
        @(negedge CLOCK_50);
        cycles++;
        if (cycles > DONE_LIMIT) begin
            $display("bus access to %h did not complete within %0d cycles", addr, DONE_LIMIT);
            fail_count++;
            break;
        end
    end
endtask

task automatic bus_write(input bus_addr_t addr, input ls_type_e t, input bus_data_t data);
    @(negedge CLOCK_50);
    bus_address      = addr;
    bus_ls_type      = t;
    bus_write_data   = data;
    bus_write_enable = 1'b1;
    @(negedge CLOCK_50);
    bus_write_enable = 1'b0;   // one cycle strobe
    wait_done(addr);
endtask

task automatic bus_read(input bus_addr_t addr, input ls_type_e t, output bus_data_t data);
    @(negedge CLOCK_50);
    bus_address     = addr;
    bus_ls_type     = t;
    bus_read_enable = 1'b1;
    @(negedge CLOCK_50);
    bus_read_enable = 1'b0;
    wait_done(addr);
    data = bus_read_data;      // valid while done is high
endtask

/* sim/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus import soc_pkg::*; ();

    localparam int CLK_PERIOD       = 100;
    localparam int PLANNED_ACCESSES = 140;
    localparam int WATCHDOG_NS      = (PLANNED_ACCESSES * 200 + 50) * CLK_PERIOD;

    logic       CLOCK_50;
    logic       KEY0;
    bus_addr_t  bus_address;
    ls_type_e   bus_ls_type;
    bus_data_t  bus_write_data;
    logic       bus_read_enable;
    logic       bus_write_enable;
    bus_data_t  bus_read_data;
    logic       bus_read_done;
    logic       bus_write_done;
    logic       ext_irq;
    logic       meip;
    logic       seip;
    logic       mtip;

    logic       chk_valid = 1'b0;
    string      chk_name;
    bus_data_t  chk_got;
    bus_data_t  chk_exp;
    logic [31:0] seed = 32'd16091;
    logic [7:0]  lanes [0:7];      // byte model of one ram double

    `include "tb_bus_tasks.svh"

    soc_bus_top i_dut (
        .CLOCK_50, .KEY0,
        .bus_address, .bus_ls_type, .bus_write_data,
        .bus_read_enable, .bus_write_enable,
        .bus_read_data, .bus_read_done, .bus_write_done,
        .ext_irq, .meip, .seip, .mtip
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    property value_matches;
        @(posedge CLOCK_50) chk_valid |-> (chk_got == chk_exp);
    endproperty

    assert property (value_matches) else begin
        $display("[FAIL] %0t ns %s expected %h got %h", $time, chk_name, chk_exp, chk_got);
        fail_count++;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic bus_data_t lanes_value();
        bus_data_t v;
        for (int i = 0; i < 8; i++) begin
            v[8*i +: 8] = lanes[i];
        end
        return v;
    endfunction

    // ext_irq pulse long enough for the gateway to see its rising edge
    task automatic pulse_irq();
        @(negedge CLOCK_50);
        ext_irq = 1'b1;
        repeat (2) @(negedge CLOCK_50);
        ext_irq = 1'b0;
        repeat (2) @(negedge CLOCK_50);
    endtask

    task automatic irq_round(input int ctx);
        bus_data_t got;
        bus_write(PLIC_ENABLE, ls_w, (ctx == 0) ? 64'h2 : 64'h0);
        bus_write(PLIC_ENABLE + CTX_ENABLE_STRIDE, ls_w, (ctx == 1) ? 64'h2 : 64'h0);
        pulse_irq();
        check("meip", meip, ctx == 0);
        check("seip", seip, ctx == 1);
        bus_read(PLIC_CLAIM + bus_addr_t'(ctx) * CTX_STRIDE, ls_w, got);
        check("plic claim", got, UART_IRQ_ID);
        check("meip", meip, 0);     // claim drops the line
        check("seip", seip, 0);
        bus_read(PLIC_PENDING, ls_w, got);
        check("plic pending", got, 0);
    endtask

    initial begin
        bus_data_t got;
        bus_data_t data;
        bus_data_t prev;
        bus_addr_t addr;
        bus_addr_t base;
        logic [31:0] word;

        KEY0             = 1'b0;
        bus_address      = '0;
        bus_ls_type      = ls_w;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        ext_irq          = 1'b0;
        repeat (5) @(negedge CLOCK_50);
        KEY0 = 1'b1;

        start_test("reset");
        check("bus_read_done", bus_read_done, 1);
        check("bus_write_done", bus_write_done, 1);
        check("meip", meip, 0);
        check("seip", seip, 0);
        check("mtip", mtip, 0);
        bus_read(MTIMECMP_ADDR, ls_d, got);
        check("mtimecmp", got, MTIMECMP_RESET);
        finish_test();

        start_test("ram round trip");
        for (int i = 0; i < 20; i++) begin
            addr = RAM_BASE + bus_addr_t'({next_random() % 512, 3'b000});
            data = {next_random(), next_random()};
            bus_write(addr, ls_d, data);
            bus_read(addr, ls_d, got);
            check("ram ld", got, data);
        end
        for (int k = 0; k < 2; k++) begin
            addr     = RAM_BASE + bus_addr_t'({next_random() % 1024, 2'b00});
            word     = next_random();
            word[31] = k[0];        // one negative, one positive word
            bus_write(addr, ls_w, {32'h0, word});
            bus_read(addr, ls_w, got);
            check("ram lw", got, {{32{word[31]}}, word});
            bus_read(addr, ls_wu, got);
            check("ram lwu", got, {32'h0, word});
        end
        finish_test();

        start_test("ram lanes");
        base = RAM_BASE + 64'h100;
        data = 64'h0123_4567_89ab_cdef;
        bus_write(base, ls_d, data);
        for (int i = 0; i < 8; i++) begin
            lanes[i] = data[8*i +: 8];
        end
        for (int o = 0; o < 8; o++) begin
            data     = {next_random(), next_random()};   // upper bits must be ignored
            lanes[o] = data[7:0];
            bus_write(base + o, ls_b, data);
            bus_read(base, ls_d, got);
            check("ram after sb", got, lanes_value());
        end
        for (int o = 0; o < 8; o += 2) begin
            data         = {next_random(), next_random()};
            lanes[o]     = data[7:0];
            lanes[o + 1] = data[15:8];
            bus_write(base + o, ls_h, data);
            bus_read(base, ls_d, got);
            check("ram after sh", got, lanes_value());
        end
        for (int o = 0; o < 8; o++) begin
            bus_read(base + o, ls_b, got);
            check("ram lb", got, {{56{lanes[o][7]}}, lanes[o]});
            bus_read(base + o, ls_bu, got);
            check("ram lbu", got, {56'h0, lanes[o]});
        end
        for (int o = 0; o < 8; o += 2) begin
            bus_read(base + o, ls_h, got);
            check("ram lh", got, {{48{lanes[o + 1][7]}}, lanes[o + 1], lanes[o]});
            bus_read(base + o, ls_hu, got);
            check("ram lhu", got, {48'h0, lanes[o + 1], lanes[o]});
        end
        finish_test();

        start_test("timer");
        bus_read(MTIME_ADDR, ls_d, prev);
        bus_write(MTIMECMP_ADDR, ls_d, prev + 64'd1_000_000);
        bus_read(MTIMECMP_ADDR, ls_d, got);
        check("mtimecmp", got, prev + 64'd1_000_000);
        check("mtip", mtip, 0);
        bus_write(MTIMECMP_ADDR, ls_d, 64'h0);
        check("mtip", mtip, 1);
        for (int i = 0; i < 4; i++) begin
            bus_read(MTIME_ADDR, ls_d, got);
            check("mtime increasing", got > prev, 1);   // ticks every clock between reads
            prev = got;
        end
        finish_test();

        start_test("plic");
        for (int id = 0; id < PLIC_SOURCES; id++) begin
            data = bus_data_t'(next_random() % 8);
            bus_write(PLIC_BASE + bus_addr_t'(4 * id), ls_w, data);
            bus_read(PLIC_BASE + bus_addr_t'(4 * id), ls_w, got);
            check("plic priority", got, data);
        end
        for (int ctx = 0; ctx < 2; ctx++) begin
            data = {32'h0, next_random()};
            bus_write(PLIC_ENABLE + bus_addr_t'(ctx) * CTX_ENABLE_STRIDE, ls_w, data);
            bus_read(PLIC_ENABLE + bus_addr_t'(ctx) * CTX_ENABLE_STRIDE, ls_w, got);
            check("plic enable", got, data);
            data = bus_data_t'(next_random() % 8);
            bus_write(PLIC_THRESHOLD + bus_addr_t'(ctx) * CTX_STRIDE, ls_w, data);
            bus_read(PLIC_THRESHOLD + bus_addr_t'(ctx) * CTX_STRIDE, ls_w, got);
            check("plic threshold", got, data);
        end
        irq_round(0);   // machine context
        irq_round(1);   // supervisor context
        finish_test();

        start_test("unmapped");
        bus_read(64'h0000_0000_1000_0000, ls_d, got);
        check("unmapped read data", got, 0);
        finish_test();

        $display("%0d tests, %0d checks, %0d failures", test_count, check_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+sim
hdl/soc_pkg.sv
hdl/bus_fabric.sv
hdl/local_ram.sv
hdl/plic_regs.sv
hdl/plic_gateway.sv
hdl/machine_timer.sv
hdl/soc_bus_top.sv
sim/tb_soc_bus.sv
